//--- hw/host_port_pkg.sv
package host_port_pkg;

    // Serial link word size
    localparam int SPI_WORD_BITS = 32;

    // Serial command buffer
    localparam int FIFO_DEPTH     = 64;
    localparam int FIFO_THRESHOLD = 16;

    // Idle cycles on rxfn that close a parallel packet
    localparam int IDLE_CYCLES = 16;

    // Occupancy count, holds 0 up to FIFO_DEPTH
    typedef logic [6:0] fifo_level_t;

    // Parallel port read cycle
    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        SAMPLE,
        RECOVER
    } rd_state_t;

endpackage

//--- hw/host_stream_pkg.sv
package host_stream_pkg;

    // Parallel port data word
    typedef logic [15:0] half_word_t;

    // Command word on the merged stream
    typedef logic [31:0] cmd_word_t;

    // Beat of the 16-bit parallel stream
    typedef struct packed {
        half_word_t data;
        logic       last;
    } half_beat_t;

    // Beat of the 32-bit command streams
    typedef struct packed {
        cmd_word_t data;
        logic      last;
    } cmd_beat_t;

endpackage

//--- hw/spi_word_receiver.sv
`timescale 1ns/1ps

module spi_word_receiver (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       serial_mosi,
    input  logic                       serial_sck,
    input  logic                       serial_ncs,
    output logic                       spi_valid,
    output host_stream_pkg::cmd_beat_t spi_beat,
    input  logic                       spi_ready
);
    import host_port_pkg::*;
    import host_stream_pkg::*;

    logic [2:0]                       sck_sync;
    logic [2:0]                       ncs_sync;
    logic [2:0]                       mosi_sync;
    logic                             sck_rise;
    logic                             ncs_rise;
    logic                             close_req;
    logic                             word_done;
    logic [$clog2(SPI_WORD_BITS)-1:0] bit_cnt;
    cmd_word_t                        shift_word;
    cmd_word_t                        pending_word;
    logic                             pending_valid;
    logic                             load_next;
    logic                             load_last;

    // A finished word pushes the pending one out, chip select rise flushes it as last
    assign load_next = word_done && spi_ready;
    assign load_last = close_req && pending_valid && (!spi_valid || spi_ready) && !load_next;

    // Two sync stages, a third for edge detection, edges registered
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync  <= '0;
            ncs_sync  <= '1;
            mosi_sync <= '0;
            sck_rise  <= 1'b0;
            ncs_rise  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[1:0], serial_sck};
            ncs_sync  <= {ncs_sync[1:0], serial_ncs};
            mosi_sync <= {mosi_sync[1:0], serial_mosi};
            sck_rise  <= sck_sync[1] && !sck_sync[2];
            ncs_rise  <= ncs_sync[1] && !ncs_sync[2];
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            word_done <= 1'b0;
            close_req <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (load_last || !pending_valid) begin
                close_req <= 1'b0;
            end
            if (ncs_rise) begin
                // Partial word is dropped
                bit_cnt   <= '0;
                close_req <= 1'b1;
            end else if (sck_rise && !ncs_sync[2]) begin
                if (bit_cnt == SPI_WORD_BITS - 1) begin
                    bit_cnt   <= '0;
                    word_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // MSB first
    always_ff @(posedge aclk) begin
        if (sck_rise && !ncs_sync[2]) begin
            shift_word <= {shift_word[SPI_WORD_BITS-2:0], mosi_sync[2]};
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pending_valid <= 1'b0;
            spi_valid     <= 1'b0;
        end else begin
            if (spi_valid && spi_ready) begin
                spi_valid <= 1'b0;
            end
            if (load_next) begin
                spi_valid     <= pending_valid;
                pending_valid <= 1'b1;
            end else if (load_last) begin
                spi_valid     <= 1'b1;
                pending_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load_next) begin
            spi_beat.data <= pending_word;
            spi_beat.last <= 1'b0;
            pending_word  <= shift_word;
        end else if (load_last) begin
            spi_beat.data <= pending_word;
            spi_beat.last <= 1'b1;
        end
    end

endmodule

//--- hw/command_fifo.sv
`timescale 1ns/1ps

module command_fifo (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  host_stream_pkg::cmd_beat_t in_beat,
    output logic                       in_ready,
    output logic                       out_valid,
    output host_stream_pkg::cmd_beat_t out_beat,
    input  logic                       out_ready,
    output logic                       serial_cts
);
    import host_port_pkg::*;
    import host_stream_pkg::*;

    cmd_beat_t                     mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fifo_level_t                   level;
    logic                          push;
    logic                          load_out;

    assign in_ready = (level != fifo_level_t'(FIFO_DEPTH));
    assign push     = in_valid && in_ready;
    // Refill the output register whenever it empties
    assign load_out = (level != '0) && (!out_valid || out_ready);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            level      <= '0;
            out_valid  <= 1'b0;
            serial_cts <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            level <= level + fifo_level_t'(push) - fifo_level_t'(load_out);
            // Host may send while more than FIFO_THRESHOLD entries are free
            serial_cts <= level < fifo_level_t'(FIFO_DEPTH - FIFO_THRESHOLD);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
        if (load_out) begin
            out_beat <= mem[rd_ptr];
        end
    end

endmodule

//--- hw/parallel_port_reader.sv
`timescale 1ns/1ps

module parallel_port_reader (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        fmc_rxfn,
    input  host_stream_pkg::half_word_t fmc_data,
    output logic                        fmc_rdn,
    output logic                        out_valid,
    output host_stream_pkg::half_beat_t out_beat,
    input  logic                        out_ready
);
    import host_port_pkg::*;
    import host_stream_pkg::*;

    rd_state_t                          state;
    half_word_t                         hold_data;
    logic                               hold_valid;
    logic [$clog2(IDLE_CYCLES+1)-1:0]   idle_cnt;
    logic                               out_free;
    logic                               start;
    logic                               close;

    assign out_free = !out_valid || out_ready;
    assign start    = (state == IDLE) && !fmc_rxfn && out_free;
    // Long enough gap on rxfn ends the packet
    assign close    = (state == IDLE) && hold_valid && out_free &&
                      (idle_cnt == IDLE_CYCLES);

    // Strobe low during STROBE and SAMPLE
    assign fmc_rdn = !((state == STROBE) || (state == SAMPLE));

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= start ? STROBE : IDLE;
                STROBE:  state <= SAMPLE;
                SAMPLE:  state <= RECOVER;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (!fmc_rxfn) begin
            idle_cnt <= '0;
        end else if (idle_cnt != IDLE_CYCLES) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (state == SAMPLE) begin
                // Previous word was not the last one
                if (hold_valid) begin
                    out_valid <= 1'b1;
                end
                hold_valid <= 1'b1;
            end else if (close) begin
                out_valid  <= 1'b1;
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (state == SAMPLE) begin
            hold_data     <= fmc_data;
            out_beat.data <= hold_data;
            out_beat.last <= 1'b0;
        end else if (close) begin
            out_beat.data <= hold_data;
            out_beat.last <= 1'b1;
        end
    end

endmodule

//--- hw/word_packer.sv
`timescale 1ns/1ps

module word_packer (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  host_stream_pkg::half_beat_t in_beat,
    output logic                        in_ready,
    output logic                        out_valid,
    output host_stream_pkg::cmd_beat_t  out_beat,
    input  logic                        out_ready
);
    import host_stream_pkg::*;

    half_word_t low_half;
    logic       have_low;
    logic       accept;
    logic       emit;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;
    // Second half, or a lone first half that ends the packet
    assign emit     = accept && (have_low || in_beat.last);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            have_low  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (emit) begin
                out_valid <= 1'b1;
                have_low  <= 1'b0;
            end else if (accept) begin
                have_low <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && !have_low) begin
            low_half <= in_beat.data;
        end
        if (emit) begin
            // Odd packet gets a zero upper half
            out_beat.data <= have_low ? {in_beat.data, low_half} : {16'h0000, in_beat.data};
            out_beat.last <= in_beat.last;
        end
    end

endmodule

//--- hw/stream_arbiter.sv
`timescale 1ns/1ps

module stream_arbiter (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       ser_valid,
    input  host_stream_pkg::cmd_beat_t ser_beat,
    output logic                       ser_ready,
    input  logic                       pk_valid,
    input  host_stream_pkg::cmd_beat_t pk_beat,
    output logic                       pk_ready,
    output logic                       m_valid,
    output host_stream_pkg::cmd_beat_t m_beat,
    input  logic                       m_ready
);
    import host_stream_pkg::*;

    logic      locked;
    logic      src_pk;
    logic      sel_pk;
    logic      out_free;
    logic      take;
    cmd_beat_t sel_beat;

    // Serial wins when no packet is in flight
    assign sel_pk    = locked ? src_pk : (!ser_valid && pk_valid);
    assign out_free  = !m_valid || m_ready;
    assign ser_ready = out_free && !sel_pk;
    assign pk_ready  = out_free && sel_pk;
    assign take      = sel_pk ? (pk_valid && pk_ready) : (ser_valid && ser_ready);
    assign sel_beat  = sel_pk ? pk_beat : ser_beat;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            locked  <= 1'b0;
            src_pk  <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            if (m_valid && m_ready) begin
                m_valid <= 1'b0;
            end
            if (take) begin
                m_valid <= 1'b1;
                src_pk  <= sel_pk;
                // Stay on this source until its last beat has moved
                locked  <= !sel_beat.last;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            m_beat <= sel_beat;
        end
    end

endmodule

//--- hw/host_interface.sv
`timescale 1ns/1ps

module host_interface (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        serial_reset,
    input  logic                        serial_mosi,
    input  logic                        serial_sck,
    input  logic                        serial_ncs,
    output logic                        serial_cts,
    input  logic                        fmc_reset,
    input  logic                        fmc_rxfn,
    output logic                        fmc_rdn,
    input  host_stream_pkg::half_word_t fmc_data,
    output logic                        m_valid,
    output host_stream_pkg::cmd_beat_t  m_beat,
    input  logic                        m_ready,
    output logic                        host_reset
);
    import host_stream_pkg::*;

    logic       spi_valid;
    logic       spi_ready;
    cmd_beat_t  spi_beat;
    logic       ser_valid;
    logic       ser_ready;
    cmd_beat_t  ser_beat;
    logic       par_valid;
    logic       par_ready;
    half_beat_t par_beat;
    logic       pk_valid;
    logic       pk_ready;
    cmd_beat_t  pk_beat;

    // Either host pulling its reset pin low resets the system
    assign host_reset = !(serial_reset && fmc_reset);

    spi_word_receiver spi_rx_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .serial_mosi (serial_mosi),
        .serial_sck  (serial_sck),
        .serial_ncs  (serial_ncs),
        .spi_valid   (spi_valid),
        .spi_beat    (spi_beat),
        .spi_ready   (spi_ready)
    );

    command_fifo cmd_fifo_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .in_valid   (spi_valid),
        .in_beat    (spi_beat),
        .in_ready   (spi_ready),
        .out_valid  (ser_valid),
        .out_beat   (ser_beat),
        .out_ready  (ser_ready),
        .serial_cts (serial_cts)
    );

    parallel_port_reader par_rd_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .fmc_rxfn  (fmc_rxfn),
        .fmc_data  (fmc_data),
        .fmc_rdn   (fmc_rdn),
        .out_valid (par_valid),
        .out_beat  (par_beat),
        .out_ready (par_ready)
    );

    word_packer packer_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (par_valid),
        .in_beat   (par_beat),
        .in_ready  (par_ready),
        .out_valid (pk_valid),
        .out_beat  (pk_beat),
        .out_ready (pk_ready)
    );

    stream_arbiter arb_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .ser_valid (ser_valid),
        .ser_beat  (ser_beat),
        .ser_ready (ser_ready),
        .pk_valid  (pk_valid),
        .pk_beat   (pk_beat),
        .pk_ready  (pk_ready),
        .m_valid   (m_valid),
        .m_beat    (m_beat),
        .m_ready   (m_ready)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Reset held for 3 clock cycles
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge aclk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- tb/host_interface_tb.sv
`timescale 1ns/1ps

module host_interface_tb;
    import host_port_pkg::*;
    import host_stream_pkg::*;

    // Worst case stimulus sizes over all tests
    localparam int SER_WORDS_MAX  = 200;
    localparam int PAR_HALVES_MAX = 304;
    localparam int PACKETS_MAX    = 57;
    localparam int CYCLE_LIMIT    = 2 * (SER_WORDS_MAX * SPI_WORD_BITS * 10 +
                                         PAR_HALVES_MAX * 4 + PACKETS_MAX * 100 + 1000);

    logic        aclk;
    logic        rst_n;
    logic        serial_reset;
    logic        serial_mosi;
    logic        serial_sck;
    logic        serial_ncs;
    logic        serial_cts;
    logic        fmc_reset;
    logic        fmc_rxfn;
    logic        fmc_rdn;
    half_word_t  fmc_data;
    logic        m_valid;
    cmd_beat_t   m_beat;
    logic        m_ready;
    logic        host_reset;

    logic [31:0] ser_exp_data[$];
    logic        ser_exp_last[$];
    logic [31:0] par_exp_data[$];
    logic        par_exp_last[$];
    logic [15:0] ft_queue[$];
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          ser_sent = 0;
    int          ser_rcvd = 0;
    int          par_sent = 0;
    int          par_done = 0;
    int          ready_mode = 0;
    int          cycle_cnt = 0;
    int          stall_jobs = 0;
    logic        in_packet = 1'b0;
    logic        cur_ser = 1'b0;

    tb_clock_gen clk_gen_i (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    host_interface dut_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .serial_reset (serial_reset),
        .serial_mosi  (serial_mosi),
        .serial_sck   (serial_sck),
        .serial_ncs   (serial_ncs),
        .serial_cts   (serial_cts),
        .fmc_reset    (fmc_reset),
        .fmc_rxfn     (fmc_rxfn),
        .fmc_rdn      (fmc_rdn),
        .fmc_data     (fmc_data),
        .m_valid      (m_valid),
        .m_beat       (m_beat),
        .m_ready      (m_ready),
        .host_reset   (host_reset)
    );

    task automatic step(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns %s", $time, msg);
        errors++;
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // Mode 0 shifting, MSB first, sck half period of 5 cycles
    task automatic send_serial_packet(input int n);
        logic [31:0] words[$];
        logic [31:0] w;
        for (int i = 0; i < n; i++) begin
            w = $urandom;
            w[31:24] = 8'hA5;
            words.push_back(w);
            ser_exp_data.push_back(w);
            ser_exp_last.push_back(i == n - 1);
        end
        serial_ncs = 1'b0;
        step(5);
        foreach (words[i]) begin
            while (!serial_cts) step(1);
            for (int b = 31; b >= 0; b--) begin
                serial_mosi = words[i][b];
                step(5);
                serial_sck = 1'b1;
                step(5);
                serial_sck = 1'b0;
            end
            ser_sent++;
        end
        step(5);
        serial_ncs = 1'b1;
        step(20);
    endtask

    // Queues the halves and waits until the packet has left the DUT
    task automatic send_parallel_packet(input int n);
        logic [15:0] halves[$];
        logic [15:0] h;
        int          target;
        for (int i = 0; i < n; i++) begin
            h = 16'($urandom);
            if (i % 2 == 1) h[15:8] = 8'h5A;
            halves.push_back(h);
        end
        for (int i = 0; i < n; i += 2) begin
            if (i + 1 < n) begin
                par_exp_data.push_back({halves[i+1], halves[i]});
                par_exp_last.push_back(i + 2 >= n);
            end else begin
                par_exp_data.push_back({16'h0000, halves[i]});
                par_exp_last.push_back(1'b1);
            end
        end
        par_sent++;
        target = par_sent;
        foreach (halves[i]) ft_queue.push_back(halves[i]);
        while (par_done < target) step(1);
    endtask

    task automatic wait_drain();
        while (ser_exp_data.size() != 0 || par_exp_data.size() != 0) step(1);
        step(10);
    endtask

    task automatic check_beat(input cmd_beat_t beat);
        logic        is_ser;
        logic        avail;
        logic [31:0] exp_data;
        logic        exp_last;
        is_ser = (beat.data[31:24] == 8'hA5);
        assert (!in_packet || is_ser == cur_ser) else
            report_fail($sformatf("packets interleaved at beat %h", beat.data));
        avail = is_ser ? (ser_exp_data.size() != 0) : (par_exp_data.size() != 0);
        assert (avail) else
            report_fail($sformatf("unexpected beat %h", beat.data));
        if (avail) begin
            if (is_ser) begin
                exp_data = ser_exp_data.pop_front();
                exp_last = ser_exp_last.pop_front();
                ser_rcvd++;
            end else begin
                exp_data = par_exp_data.pop_front();
                exp_last = par_exp_last.pop_front();
            end
            assert (beat.data == exp_data && beat.last == exp_last) else
                report_fail($sformatf("beat %h last %b, expected %h last %b",
                                      beat.data, beat.last, exp_data, exp_last));
        end
        if (beat.last && !is_ser) par_done++;
        in_packet = !beat.last;
        cur_ser   = is_ser;
    endtask

    // Outputs and m_ready are both stable at the falling edge
    always @(negedge aclk) begin
        if (rst_n && m_valid && m_ready) check_beat(m_beat);
    end

    initial begin
        m_ready = 1'b1;
        forever begin
            @(posedge aclk);
            #1;
            case (ready_mode)
                0:       m_ready = 1'b1;
                1:       m_ready = ($urandom % 4) != 0;
                default: m_ready = 1'b0;
            endcase
        end
    end

    // FT245 source: next word appears when rdn falls
    initial begin
        logic rdn_seen;
        fmc_rxfn = 1'b1;
        fmc_data = '0;
        rdn_seen = 1'b1;
        forever begin
            @(posedge aclk);
            #1;
            if (!fmc_rdn && rdn_seen && ft_queue.size() != 0) fmc_data = ft_queue.pop_front();
            rdn_seen = fmc_rdn;
            fmc_rxfn = (ft_queue.size() == 0);
        end
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int err_start;
        void'($urandom(3922));
        serial_reset = 1'b1;
        fmc_reset    = 1'b1;
        serial_mosi  = 1'b0;
        serial_sck   = 1'b0;
        serial_ncs   = 1'b1;
        @(posedge rst_n);
        step(5);

        err_start = errors;
        repeat (8) send_serial_packet(1 + $urandom % 6);
        wait_drain();
        report_test("serial packets", err_start);

        err_start = errors;
        for (int i = 0; i < 8; i++) send_parallel_packet(2 * (1 + $urandom % 6) - i % 2);
        wait_drain();
        report_test("parallel packets", err_start);

        err_start = errors;
        fork
            repeat (6) send_serial_packet(1 + $urandom % 6);
            for (int i = 0; i < 6; i++) send_parallel_packet(1 + $urandom % 12);
        join
        wait_drain();
        report_test("concurrent sources", err_start);

        err_start = errors;
        ready_mode = 1;
        fork
            repeat (6) send_serial_packet(1 + $urandom % 6);
            for (int i = 0; i < 6; i++) send_parallel_packet(1 + $urandom % 12);
        join
        wait_drain();
        // Output held off until both links stall at the pins
        ready_mode = 2;
        fork
            begin
                repeat (16) send_serial_packet(5);
                stall_jobs++;
            end
        join_none
        while (serial_cts) step(1);
        step(400);
        // Parallel packet long enough to still be reading if rdn ignored the stall
        fork
            begin
                send_parallel_packet(64);
                stall_jobs++;
            end
        join_none
        step(40);
        repeat (400) begin
            step(1);
            assert (fmc_rdn) else report_fail("fmc_rdn low while output stalled");
            assert (ser_sent - ser_rcvd <= FIFO_DEPTH) else
                report_fail($sformatf("%0d serial words outstanding", ser_sent - ser_rcvd));
        end
        ready_mode = 1;
        while (stall_jobs < 2) step(1);
        wait_drain();
        assert (serial_cts) else report_fail("serial_cts low with the serial buffer empty");
        report_test("back-pressure", err_start);

        err_start = errors;
        ready_mode = 0;
        for (int c = 0; c < 4; c++) begin
            serial_reset = c[1];
            fmc_reset    = c[0];
            step(1);
            assert (host_reset == (!serial_reset || !fmc_reset)) else
                report_fail($sformatf("host_reset %b for serial_reset %b fmc_reset %b",
                                      host_reset, serial_reset, fmc_reset));
        end
        serial_reset = 1'b1;
        fmc_reset    = 1'b1;
        report_test("system reset", err_start);

        $display("Tests: %0d ok, %0d with errors, %0d check errors in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- host_interface.f
hw/host_port_pkg.sv
hw/host_stream_pkg.sv
hw/spi_word_receiver.sv
hw/command_fifo.sv
hw/parallel_port_reader.sv
hw/word_packer.sv
hw/stream_arbiter.sv
hw/host_interface.sv
tb/tb_clock_gen.sv
tb/host_interface_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module host_interface_tb -Mdir obj_dir -f host_interface.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vhost_interface_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1
